/* src/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Core sizing for the memory issue stage
////////////////////////////////////////////////////////////////////////////

// Reservation station slots, 4 or 8
`define MEMRS_DEPTH 4

// Physical register file
`define PHYS_REGS 32

// Result broadcast ports
`define CDB_WIDTH 2

// Reorder buffer entries, sets the rob id width
`define ROB_DEPTH 16

// Architectural data width
`define XLEN 32

`endif

/* src/mem_rs_pkg.sv */
`include "cpu_settings.svh"

package mem_rs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic vectors
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`XLEN-1:0]                 word_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0]    phys_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0]    rob_id_t;
    typedef logic [$clog2(`MEMRS_DEPTH)-1:0]  rs_idx_t;
    typedef logic [3:0]                       byte_mask_t;

    // Loads first, stores after
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        rob_id_t    rob_id;
        phys_reg_t  rs1_phy;
        logic       rs1_ready;
        phys_reg_t  rs2_phy;
        logic       rs2_ready;
        word_t      imm;
        mem_op_t    mem_op;
    } mem_uop_t;

    // Same layout as the micro-op, ready bits move on wakeup
    typedef struct packed {
        rob_id_t    rob_id;
        phys_reg_t  rs1_phy;
        logic       rs1_ready;
        phys_reg_t  rs2_phy;
        logic       rs2_ready;
        word_t      imm;
        mem_op_t    mem_op;
    } mem_rs_entry_t;

    typedef struct packed {
        logic       valid;
        phys_reg_t  tag;
        word_t      value;
    } cdb_t;

    typedef struct packed {
        rob_id_t    rob_id;
        mem_op_t    mem_op;
        word_t      addr;
        byte_mask_t byte_mask;
        word_t      store_data;
        logic       misaligned;
    } agu_lsq_t;

endpackage

/* src/rs_entry.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module rs_entry (
    input  logic                                     clk,
    input  logic                                     reset,

    input  logic                                     push,
    input  mem_rs_pkg::mem_rs_entry_t                entry_in,
    input  logic                                     grant,
    input  mem_rs_pkg::cdb_t [`CDB_WIDTH-1:0]        cdb,

    output logic                                     valid,
    output logic                                     request,
    output mem_rs_pkg::mem_rs_entry_t                entry
);

    logic                        valid_q;
    mem_rs_pkg::mem_rs_entry_t   entry_q;
    mem_rs_pkg::mem_rs_entry_t   entry_src;
    mem_rs_pkg::mem_rs_entry_t   entry_next;
    logic                        rs1_hit;
    logic                        rs2_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Wakeup
    ////////////////////////////////////////////////////////////////////////////

    // A new entry sees the same CDB as a resident one
    always_comb begin
        entry_src = push ? entry_in : entry_q;
        rs1_hit   = 1'b0;
        rs2_hit   = 1'b0;
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            if (cdb[i].valid && (cdb[i].tag == entry_src.rs1_phy)) begin
                rs1_hit = 1'b1;
            end
            if (cdb[i].valid && (cdb[i].tag == entry_src.rs2_phy)) begin
                rs2_hit = 1'b1;
            end
        end
        entry_next           = entry_src;
        entry_next.rs1_ready = entry_src.rs1_ready | rs1_hit;
        entry_next.rs2_ready = entry_src.rs2_ready | rs2_hit;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slot state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (push) begin
            valid_q <= 1'b1;
        end else if (grant) begin
            valid_q <= 1'b0;
        end
    end

    // Payload follows wakeup every cycle
    always_ff @(posedge clk) begin
        entry_q <= entry_next;
    end

    assign valid   = valid_q;
    assign entry   = entry_q;
    assign request = valid_q && entry_q.rs1_ready && entry_q.rs2_ready;

    // Dispatch and select never target the same slot
    push_grant_excl: assert property (@(posedge clk) disable iff (reset)
        !(push && grant));

    // Dispatch only fills free slots
    push_free_slot: assert property (@(posedge clk) disable iff (reset)
        push |-> !valid_q);

endmodule

/* src/mem_rs_dispatch.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_rs_dispatch (
    input  logic                                dispatch_valid,
    input  mem_rs_pkg::mem_uop_t                dispatch_uop,
    output logic                                dispatch_ready,

    input  logic [`MEMRS_DEPTH-1:0]             slot_valid,
    output logic [`MEMRS_DEPTH-1:0]             push,
    output mem_rs_pkg::mem_rs_entry_t           push_entry
);

    mem_rs_pkg::rs_idx_t   free_idx;
    logic                  any_free;
    logic                  transfer;

    // Scan from the top down so the lowest free slot is found last
    always_comb begin
        free_idx = '0;
        any_free = 1'b0;
        for (int i = `MEMRS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = mem_rs_pkg::rs_idx_t'(i);
                any_free = 1'b1;
            end
        end
    end

    assign dispatch_ready = any_free;
    assign transfer       = dispatch_valid && any_free;

    always_comb begin
        push = '0;
        if (transfer) begin
            push[free_idx] = 1'b1;
        end
    end

    // Micro-op to slot format
    always_comb begin
        push_entry.rob_id    = dispatch_uop.rob_id;
        push_entry.rs1_phy   = dispatch_uop.rs1_phy;
        push_entry.rs1_ready = dispatch_uop.rs1_ready;
        push_entry.rs2_phy   = dispatch_uop.rs2_phy;
        push_entry.rs2_ready = dispatch_uop.rs2_ready;
        push_entry.imm       = dispatch_uop.imm;
        push_entry.mem_op    = dispatch_uop.mem_op;
    end

endmodule

/* src/mem_rs_select.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_rs_select (
    input  logic [`MEMRS_DEPTH-1:0]                             request,
    input  mem_rs_pkg::mem_rs_entry_t [`MEMRS_DEPTH-1:0]        entries,
    input  logic                                                issue_ready,

    output logic [`MEMRS_DEPTH-1:0]                             grant,
    output logic                                                issue_valid,
    output mem_rs_pkg::mem_rs_entry_t                           issue_entry
);

    logic found;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed priority where slot 0 wins
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        grant = '0;
        found = 1'b0;
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            if (request[i] && !found && issue_ready) begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    assign issue_valid = found;

    // One-hot mux of the winner
    always_comb begin
        issue_entry = '0;
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            if (grant[i]) begin
                issue_entry = mem_rs_pkg::mem_rs_entry_t'(issue_entry | entries[i]);
            end
        end
    end

endmodule

/* src/phys_reg_file.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module phys_reg_file (
    input  logic                                  clk,
    input  logic                                  reset,

    input  mem_rs_pkg::cdb_t [`CDB_WIDTH-1:0]     cdb,

    input  mem_rs_pkg::phys_reg_t                 rs1_phy,
    input  mem_rs_pkg::phys_reg_t                 rs2_phy,
    output mem_rs_pkg::word_t                     rs1_value,
    output mem_rs_pkg::word_t                     rs2_value
);

    mem_rs_pkg::word_t regs [`PHYS_REGS];

    // Every register reads as zero out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `PHYS_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < `CDB_WIDTH; i++) begin
                if (cdb[i].valid) begin
                    regs[cdb[i].tag] <= cdb[i].value;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports with CDB forwarding
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rs1_value = regs[rs1_phy];
        rs2_value = regs[rs2_phy];
        for (int i = 0; i < `CDB_WIDTH; i++) begin
            if (cdb[i].valid && (cdb[i].tag == rs1_phy)) begin
                rs1_value = cdb[i].value;
            end
            if (cdb[i].valid && (cdb[i].tag == rs2_phy)) begin
                rs2_value = cdb[i].value;
            end
        end
    end

    // Rename hands out each tag once, so broadcasts never collide
    for (genvar i = 0; i < `CDB_WIDTH; i++) begin : g_cdb_a
        for (genvar j = i + 1; j < `CDB_WIDTH; j++) begin : g_cdb_b
            cdb_tag_unique: assert property (@(posedge clk) disable iff (reset)
                !(cdb[i].valid && cdb[j].valid && (cdb[i].tag == cdb[j].tag)));
        end
    end

endmodule

/* src/fu_agu.sv */
`timescale 1ns/1ps

module fu_agu (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          issue_valid,
    input  mem_rs_pkg::mem_rs_entry_t     issue_entry,
    input  mem_rs_pkg::word_t             rs1_value,
    input  mem_rs_pkg::word_t             rs2_value,
    output logic                          issue_ready,

    output logic                          lsq_valid,
    input  logic                          lsq_ready,
    output mem_rs_pkg::agu_lsq_t          lsq_req
);

    mem_rs_pkg::word_t        addr;
    mem_rs_pkg::byte_mask_t   size_mask;
    mem_rs_pkg::byte_mask_t   byte_mask;
    mem_rs_pkg::word_t        lane_data;
    mem_rs_pkg::word_t        lane_keep;
    mem_rs_pkg::agu_lsq_t     req_next;
    logic                     is_store;
    logic                     misaligned;
    logic                     valid_q;
    mem_rs_pkg::agu_lsq_t     req_q;

    assign addr = rs1_value + issue_entry.imm;

    // Access size and store lane replication
    always_comb begin
        size_mask  = 4'b1111;
        lane_data  = rs2_value;
        is_store   = 1'b0;
        misaligned = 1'b0;
        case (issue_entry.mem_op)
            mem_rs_pkg::LB, mem_rs_pkg::LBU, mem_rs_pkg::SB: begin
                size_mask = 4'b0001;
                lane_data = {4{rs2_value[7:0]}};
            end
            mem_rs_pkg::LH, mem_rs_pkg::LHU, mem_rs_pkg::SH: begin
                size_mask  = 4'b0011;
                lane_data  = {2{rs2_value[15:0]}};
                misaligned = addr[0];
            end
            default: begin
                misaligned = |addr[1:0];
            end
        endcase
        is_store = (issue_entry.mem_op == mem_rs_pkg::SB) ||
                   (issue_entry.mem_op == mem_rs_pkg::SH) ||
                   (issue_entry.mem_op == mem_rs_pkg::SW);
    end

    // Lanes past byte 3 fall off the mask
    assign byte_mask = size_mask << addr[1:0];
    assign lane_keep = {{8{byte_mask[3]}}, {8{byte_mask[2]}},
                        {8{byte_mask[1]}}, {8{byte_mask[0]}}};

    always_comb begin
        req_next.rob_id     = issue_entry.rob_id;
        req_next.mem_op     = issue_entry.mem_op;
        req_next.addr       = addr;
        req_next.byte_mask  = byte_mask;
        req_next.store_data = is_store ? (lane_data & lane_keep) : '0;
        req_next.misaligned = misaligned;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register toward the LSQ
    ////////////////////////////////////////////////////////////////////////////

    assign issue_ready = !valid_q || lsq_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (issue_valid && issue_ready) begin
            valid_q <= 1'b1;
        end else if (lsq_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            req_q <= req_next;
        end
    end

    assign lsq_valid = valid_q;
    assign lsq_req   = req_q;

    lsq_hold: assert property (@(posedge clk) disable iff (reset)
        (lsq_valid && !lsq_ready) |=> (lsq_valid && $stable(lsq_req)));

endmodule

/* src/mem_rs_top.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_rs_top (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  dispatch_valid,
    output logic                                  dispatch_ready,
    input  mem_rs_pkg::mem_uop_t                  dispatch_uop,

    input  mem_rs_pkg::cdb_t [`CDB_WIDTH-1:0]     cdb,

    output logic                                  lsq_valid,
    input  logic                                  lsq_ready,
    output mem_rs_pkg::agu_lsq_t                  lsq_req
);

    logic [`MEMRS_DEPTH-1:0]                         slot_valid;
    logic [`MEMRS_DEPTH-1:0]                         slot_request;
    logic [`MEMRS_DEPTH-1:0]                         slot_grant;
    logic [`MEMRS_DEPTH-1:0]                         slot_push;
    mem_rs_pkg::mem_rs_entry_t                       push_entry;
    mem_rs_pkg::mem_rs_entry_t [`MEMRS_DEPTH-1:0]    slot_entries;

    logic                                            issue_valid;
    logic                                            issue_ready;
    mem_rs_pkg::mem_rs_entry_t                       issue_entry;
    mem_rs_pkg::word_t                               rs1_value;
    mem_rs_pkg::word_t                               rs2_value;

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch and slots
    ////////////////////////////////////////////////////////////////////////////

    mem_rs_dispatch u_dispatch (
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .slot_valid     (slot_valid),
        .push           (slot_push),
        .push_entry     (push_entry)
    );

    for (genvar i = 0; i < `MEMRS_DEPTH; i++) begin : rs_array
        rs_entry u_entry (
            .clk      (clk),
            .reset    (reset),
            .push     (slot_push[i]),
            .entry_in (push_entry),
            .grant    (slot_grant[i]),
            .cdb      (cdb),
            .valid    (slot_valid[i]),
            .request  (slot_request[i]),
            .entry    (slot_entries[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue, operand read, AGU
    ////////////////////////////////////////////////////////////////////////////

    mem_rs_select u_select (
        .request     (slot_request),
        .entries     (slot_entries),
        .issue_ready (issue_ready),
        .grant       (slot_grant),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry)
    );

    // Operands come straight from the granted entry's tags
    phys_reg_file u_prf (
        .clk       (clk),
        .reset     (reset),
        .cdb       (cdb),
        .rs1_phy   (issue_entry.rs1_phy),
        .rs2_phy   (issue_entry.rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    fu_agu u_agu (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_ready (issue_ready),
        .lsq_valid   (lsq_valid),
        .lsq_ready   (lsq_ready),
        .lsq_req     (lsq_req)
    );

endmodule

/* testbench/mem_rs_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mem_rs_tb;

    // Cycle budget summed over the tests
    localparam int TEST_CYCLES = 20 + 40 + 60 + 40 + 32 * 8 + 500;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 4;

    logic                                  clk;
    logic                                  reset;
    logic                                  dispatch_valid;
    logic                                  dispatch_ready;
    mem_rs_pkg::mem_uop_t                  dispatch_uop;
    mem_rs_pkg::cdb_t [`CDB_WIDTH-1:0]     cdb;
    logic                                  lsq_valid;
    logic                                  lsq_ready;
    mem_rs_pkg::agu_lsq_t                  lsq_req;

    mem_rs_pkg::word_t     ref_regs [`PHYS_REGS];
    mem_rs_pkg::mem_uop_t  pend_uop [`ROB_DEPTH];
    logic                  pending  [`ROB_DEPTH];
    int                    pending_count;
    int                    done_count;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;
    int                    cycle_count;
    string                 cur_test;
    logic                  stalled;
    mem_rs_pkg::agu_lsq_t  stalled_req;
    logic                  disp_done;

    mem_rs_top UUT (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_uop   (dispatch_uop),
        .cdb            (cdb),
        .lsq_valid      (lsq_valid),
        .lsq_ready      (lsq_ready),
        .lsq_req        (lsq_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic mem_rs_pkg::agu_lsq_t expected_req(mem_rs_pkg::mem_uop_t u);
        mem_rs_pkg::agu_lsq_t r;
        mem_rs_pkg::word_t    a;
        mem_rs_pkg::word_t    d;
        int                   size;
        logic [7:0]           full_mask;
        a    = ref_regs[u.rs1_phy] + u.imm;
        d    = ref_regs[u.rs2_phy];
        size = 4;
        if (u.mem_op inside {mem_rs_pkg::LB, mem_rs_pkg::LBU, mem_rs_pkg::SB}) size = 1;
        if (u.mem_op inside {mem_rs_pkg::LH, mem_rs_pkg::LHU, mem_rs_pkg::SH}) size = 2;
        full_mask    = 8'((1 << size) - 1) << a[1:0];
        r.rob_id     = u.rob_id;
        r.mem_op     = u.mem_op;
        r.addr       = a;
        r.byte_mask  = full_mask[3:0];
        r.misaligned = (size == 2) ? a[0] : ((size == 4) ? (a[1:0] != 2'b00) : 1'b0);
        r.store_data = '0;
        if (u.mem_op inside {mem_rs_pkg::SB, mem_rs_pkg::SH, mem_rs_pkg::SW}) begin
            // Lane j carries source byte j modulo the access size
            for (int j = 0; j < 4; j++) begin
                if (r.byte_mask[j]) r.store_data[8*j +: 8] = d[8*(j % size) +: 8];
            end
        end
        return r;
    endfunction

    function automatic mem_rs_pkg::mem_uop_t make_uop(int rob, int rs1, bit rdy1, int rs2,
                                                       bit rdy2, mem_rs_pkg::word_t imm,
                                                       mem_rs_pkg::mem_op_t op);
        mem_rs_pkg::mem_uop_t u;
        u.rob_id    = mem_rs_pkg::rob_id_t'(rob);
        u.rs1_phy   = mem_rs_pkg::phys_reg_t'(rs1);
        u.rs1_ready = rdy1;
        u.rs2_phy   = mem_rs_pkg::phys_reg_t'(rs2);
        u.rs2_ready = rdy2;
        u.imm       = imm;
        u.mem_op    = op;
        return u;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // LSQ monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        mem_rs_pkg::agu_lsq_t exp_req;
        if (!reset) begin
            if (stalled && lsq_valid) begin
                assert (lsq_req == stalled_req) else begin
                    $display("CHECK FAILED %s: held request expected %h actual %h",
                             cur_test, stalled_req, lsq_req);
                    errors++;
                end
            end
            stalled     = lsq_valid && !lsq_ready;
            stalled_req = lsq_req;
            if (lsq_valid && lsq_ready) begin
                assert (pending[lsq_req.rob_id]) else begin
                    $display("%s: LSQ request for rob_id %0d that is not outstanding",
                             cur_test, lsq_req.rob_id);
                    errors++;
                end
                if (pending[lsq_req.rob_id]) begin
                    exp_req = expected_req(pend_uop[lsq_req.rob_id]);
                    assert (lsq_req == exp_req) else begin
                        $display("CHECK FAILED %s: lsq_req expected %h actual %h",
                                 cur_test, exp_req, lsq_req);
                        errors++;
                    end
                    pending[lsq_req.rob_id] = 1'b0;
                    pending_count--;
                    done_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s, the DUT stopped responding",
                     cycle_count, cur_test);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic cdb_write(int port, int tag, mem_rs_pkg::word_t value);
        @(posedge clk);
        cdb[port].valid <= 1'b1;
        cdb[port].tag   <= mem_rs_pkg::phys_reg_t'(tag);
        cdb[port].value <= value;
        ref_regs[tag] = value;
        @(posedge clk);
        cdb[port].valid <= 1'b0;
    endtask

    // Optional broadcast on port 0 during the dispatch cycle
    task automatic dispatch_op(mem_rs_pkg::mem_uop_t u, bit with_cdb, int tag,
                               mem_rs_pkg::word_t value);
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch_uop   <= u;
        if (with_cdb) begin
            cdb[0].valid <= 1'b1;
            cdb[0].tag   <= mem_rs_pkg::phys_reg_t'(tag);
            cdb[0].value <= value;
            ref_regs[tag] = value;
        end
        @(negedge clk);
        while (!dispatch_ready) @(negedge clk);
        pend_uop[u.rob_id] = u;
        pending[u.rob_id]  = 1'b1;
        pending_count++;
        @(posedge clk);
        dispatch_valid <= 1'b0;
        cdb[0].valid   <= 1'b0;
    endtask

    task automatic wait_drain();
        while (pending_count > 0) @(negedge clk);
    endtask

    task automatic check_bit(string what, logic expected, logic actual);
        assert (expected === actual) else begin
            $display("CHECK FAILED %s: %s expected %0b actual %0b",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(int errors_before);
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("%s finished with %0d errors", cur_test, errors - errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic ready_issue_test();
        int e;
        e = errors;
        cur_test = "ready_issue";
        cdb_write(0, 5, 32'h0000_1000);
        cdb_write(1, 6, 32'h1234_5678);
        dispatch_op(make_uop(1, 5, 1, 6, 1, 32'h24, mem_rs_pkg::LW), 0, 0, '0);
        @(negedge clk);
        check_bit("lsq_valid one edge after transfer", 1'b0, lsq_valid);
        @(negedge clk);
        check_bit("lsq_valid two edges after dispatch", 1'b1, lsq_valid);
        wait_drain();
        finish_test(e);
    endtask

    task automatic wakeup_test();
        int e;
        e = errors;
        cur_test = "wakeup";
        cdb_write(0, 3, 32'hA1B2_C3D4);
        dispatch_op(make_uop(5, 4, 0, 3, 1, 32'h1, mem_rs_pkg::SB), 0, 0, '0);
        repeat (6) @(negedge clk);
        check_bit("store waiting on rs1", 1'b1, pending[5]);
        check_bit("lsq_valid while waiting", 1'b0, lsq_valid);
        cdb_write(1, 4, 32'h0000_2000);
        wait_drain();
        // Broadcast lands in the dispatch cycle itself
        dispatch_op(make_uop(6, 9, 0, 3, 1, 32'h0, mem_rs_pkg::SH), 1, 9, 32'h0000_3002);
        wait_drain();
        finish_test(e);
    endtask

    task automatic full_station_test();
        int e;
        e = errors;
        cur_test = "full_station";
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            dispatch_op(make_uop(i, 20 + i, 0, 3, 1, 32'h8 * i, mem_rs_pkg::SW), 0, 0, '0);
        end
        repeat (5) begin
            @(negedge clk);
            check_bit("dispatch_ready with station full", 1'b0, dispatch_ready);
        end
        cdb_write(0, 20, 32'h0000_4000);
        while (pending[0]) @(negedge clk);
        check_bit("dispatch_ready after one issue", 1'b1, dispatch_ready);
        for (int i = 1; i < `MEMRS_DEPTH; i++) cdb_write(1, 20 + i, 32'h0000_4100 * i);
        wait_drain();
        finish_test(e);
    endtask

    task automatic backpressure_test();
        int e;
        e = errors;
        cur_test = "backpressure";
        @(posedge clk);
        lsq_ready <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            dispatch_op(make_uop(8 + i, 5, 1, 6, 1, 32'h4 * i, mem_rs_pkg::LW), 0, 0, '0);
        end
        repeat (10) @(negedge clk);
        check_bit("lsq_valid held", 1'b1, lsq_valid);
        // The first dispatch owns the output register for the whole stall
        assert (lsq_req.rob_id == 8) else begin
            $display("CHECK FAILED %s: held rob_id expected %0d actual %0d",
                     cur_test, 8, lsq_req.rob_id);
            errors++;
        end
        @(posedge clk);
        lsq_ready <= 1'b1;
        wait_drain();
        @(negedge clk);
        check_bit("lsq_valid after drain", 1'b0, lsq_valid);
        finish_test(e);
    endtask

    task automatic address_corner_test();
        int e;
        mem_rs_pkg::mem_op_t op;
        e = errors;
        cur_test = "address_corners";
        cdb_write(0, 7, 32'h0000_1000);
        cdb_write(0, 8, 32'hA1B2_C3D4);
        for (int k = 0; k < 8; k++) begin
            op = mem_rs_pkg::mem_op_t'(k);
            for (int off = 0; off < 4; off++) begin
                dispatch_op(make_uop((4 * k + off) % `ROB_DEPTH, 7, 1, 8, 1,
                                     32'h10 * k + off, op), 0, 0, '0);
                wait_drain();
            end
        end
        finish_test(e);
    endtask

    task automatic random_mix_test();
        int e;
        e = errors;
        cur_test = "random_mix";
        for (int t = 1; t < `PHYS_REGS; t++) cdb_write(t % 2, t, $urandom);
        disp_done = 1'b0;
        fork
            begin
                for (int r = 0; r < `ROB_DEPTH; r++) begin
                    dispatch_op(make_uop(r, 1 + $urandom % 31, $urandom % 2,
                                         1 + $urandom % 31, $urandom % 2, $urandom,
                                         mem_rs_pkg::mem_op_t'($urandom % 8)), 0, 0, '0);
                end
                disp_done = 1'b1;
            end
            begin
                // Rebroadcasts keep register values unchanged
                while (!disp_done) begin
                    int tag;
                    tag = 1 + $urandom % 31;
                    @(posedge clk);
                    lsq_ready    <= $urandom % 2;
                    cdb[1].valid <= $urandom % 2;
                    cdb[1].tag   <= mem_rs_pkg::phys_reg_t'(tag);
                    cdb[1].value <= ref_regs[tag];
                end
                @(posedge clk);
                cdb[1].valid <= 1'b0;
                lsq_ready    <= 1'b1;
                for (int t = 1; t < `PHYS_REGS; t++) cdb_write(1, t, ref_regs[t]);
            end
        join
        wait_drain();
        finish_test(e);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h504560fc));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        cdb            = '0;
        lsq_ready      = 1'b1;
        pending_count  = 0;
        done_count     = 0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        cycle_count    = 0;
        stalled        = 1'b0;
        stalled_req    = '0;
        cur_test       = "reset";
        for (int r = 0; r < `PHYS_REGS; r++) ref_regs[r] = '0;
        for (int r = 0; r < `ROB_DEPTH; r++) pending[r] = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        ready_issue_test();
        wakeup_test();
        full_station_test();
        backpressure_test();
        address_corner_test();
        random_mix_test();

        $display("Tests run %0d, tests failed %0d, errors %0d, transfers %0d",
                 tests_run, tests_failed, errors, done_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+src
src/mem_rs_pkg.sv
src/rs_entry.sv
src/mem_rs_dispatch.sv
src/mem_rs_select.sv
src/phys_reg_file.sv
src/fu_agu.sv
src/mem_rs_top.sv
testbench/mem_rs_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the memory issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module mem_rs_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmem_rs_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
